//--- Bender.yml
package:
  name: scatter_tx

sources:
  - verilog/scatter_cfg_pkg.sv
  - verilog/scatter_stream_pkg.sv
  - verilog/scatter_run_if.sv
  - verilog/scatter_ctrl_regs.sv
  - verilog/scatter_tx_gen.sv
  - verilog/stream_fifo.sv
  - verilog/scatter_tx_stats.sv
  - verilog/scatter_top.sv
  - target: test
    files:
      - tests/scatter_props.sv
      - tests/tb_scatter.sv

//--- tests/scatter_props.sv
/*
  scatter transmit properties
  handshake stability on both ports and start/done sequencing,
  bound into the top level
*/
module scatter_props (
  input logic        ap_clk,
  input logic        ap_rst_n,
  input logic        tx_meta_valid,
  input logic        tx_meta_ready,
  input logic [31:0] tx_meta_data,
  input logic        tx_data_valid,
  input logic        tx_data_ready,
  input logic [63:0] tx_data_data,
  input logic [7:0]  tx_data_keep,
  input logic        tx_data_last,
  input logic        start,
  input logic        done,
  input logic        idle
);
  timeunit 1ns;
  timeprecision 100ps;

  logic        started;         // any start since reset
  int unsigned fail_count = 0;  // failed property checks

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      started <= 1'b0;
    end else if (start) begin
      started <= 1'b1;
    end
  end

  meta_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    tx_meta_valid && !tx_meta_ready |=> tx_meta_valid && $stable(tx_meta_data))
    else begin
      $error("tx_meta payload changed or valid dropped while stalled");
      fail_count++;
    end

  data_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    tx_data_valid && !tx_data_ready |=> tx_data_valid && $stable(tx_data_data)
    && $stable(tx_data_keep) && $stable(tx_data_last))
    else begin
      $error("tx_data payload changed or valid dropped while stalled");
      fail_count++;
    end

  quiet_before_start: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    !started |-> !tx_meta_valid && !tx_data_valid)
    else begin
      $error("stream valid raised before the first start");
      fail_count++;
    end

  done_while_busy: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    done |-> !idle)
    else begin
      $error("done pulse while the engine was idle");
      fail_count++;
    end

endmodule

bind scatter_top scatter_props u_props (
  .ap_clk, .ap_rst_n,
  .tx_meta_valid, .tx_meta_ready, .tx_meta_data,
  .tx_data_valid, .tx_data_ready, .tx_data_data, .tx_data_keep, .tx_data_last,
  .start (run.start),
  .done  (run.done),
  .idle  (u_ctrl_regs.idle)
);

//--- tests/tb_scatter.sv
/*
  testbench for the scatter transmit engine
  programs runs over APB, drives random port back-pressure and checks
  every metadata and data beat against a reference model
*/
module tb_scatter;
  timeunit 1ns;
  timeprecision 100ps;
  import scatter_cfg_pkg::*;

  typedef struct packed {
    logic [31:0] meta;
    logic [63:0] data;
    logic [7:0]  keep;
    logic        last;
  } exp_beat_t;

  logic        ap_clk;
  logic        ap_rst_n;
  logic [11:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        tx_meta_valid;
  logic        tx_meta_ready;
  logic [31:0] tx_meta_data;
  logic        tx_data_valid;
  logic        tx_data_ready;
  logic [63:0] tx_data_data;
  logic [7:0]  tx_data_keep;
  logic        tx_data_last;

  int unsigned cur_conn;
  int unsigned cur_bytes;
  int unsigned cur_num;
  logic [15:0] cur_base;
  int unsigned meta_cnt;
  int unsigned data_cnt;
  int unsigned data_pkt;
  int unsigned data_word;
  int unsigned stall_seen;  // data stalls seen at the port
  int unsigned errors;
  int unsigned err_mark;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned cycle_count;
  int unsigned cycle_limit;
  logic        bp_on;
  logic [31:0] lcg_state;

  scatter_top i_scatter_top (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int unsigned run_beats(input int unsigned nbytes, input int unsigned npkt);
    return npkt * (1 + (nbytes + 7) / 8);  // one meta word plus data words
  endfunction

  // expected beat for packet pkt, data word word
  function automatic exp_beat_t expected_beat(input int unsigned conn, input int unsigned nbytes,
                                              input logic [15:0] base, input int unsigned pkt,
                                              input int unsigned word);
    exp_beat_t   e;
    logic [15:0] sess;
    int unsigned nwords;
    int unsigned rem;
    sess   = base + 16'(pkt % conn);  // round robin, wraps in 16 bits
    nwords = (nbytes + 7) / 8;
    rem    = nbytes - 8 * word;
    e.meta = {sess, 16'(nbytes)};
    e.data = {sess, 16'(pkt), 32'(word)};
    e.keep = (rem >= 8) ? 8'hff : 8'((1 << rem) - 1);
    e.last = (word == nwords - 1);
    return e;
  endfunction

  initial begin
    ap_clk = 1'b0;
    forever #2 ap_clk = ~ap_clk;
  end

  // port back-pressure, ready high about 3 cycles in 4
  initial begin
    tx_meta_ready = 1'b1;
    tx_data_ready = 1'b1;
    lcg_state     = 32'd17501;
    forever begin
      @(posedge ap_clk);
      #1;
      if (bp_on) begin
        lcg_state     = lcg_next(lcg_state);
        tx_meta_ready = |lcg_state[17:16];
        tx_data_ready = |lcg_state[25:24];
      end else begin
        tx_meta_ready = 1'b1;
        tx_data_ready = 1'b1;
      end
    end
  end

  // beats 2..5 under test, plus APB and polling margin per test
  initial begin
    cycle_limit = 2 * (run_beats(64, 6) + run_beats(21, 5) + run_beats(44, 8)
                  + run_beats(16, 4)) + 200 * 6;
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge ap_clk);
      cycle_count++;
    end
    $display("timeout, run still busy after %0d cycles", cycle_count);
    $display("sim failed");
    $finish;
  end

  // compare accepted beats, sampled mid-cycle before the transfer edge
  always @(negedge ap_clk) begin
    exp_beat_t e;
    if (ap_rst_n) begin
      if (tx_meta_valid && tx_meta_ready) begin
        assert (meta_cnt < cur_num) else begin
          $display("metadata beat arrived beyond the packet count");
          errors++;
        end
        if (meta_cnt < cur_num) begin
          e = expected_beat(cur_conn, cur_bytes, cur_base, meta_cnt, 0);
          assert (tx_meta_data == e.meta) else begin
            $display("error tx_meta_data got %h expected %h", tx_meta_data, e.meta);
            errors++;
          end
        end
        meta_cnt++;
      end
      if (tx_data_valid && tx_data_ready) begin
        assert (data_pkt < cur_num) else begin
          $display("data beat arrived beyond the packet count");
          errors++;
        end
        if (data_pkt < cur_num) begin
          e = expected_beat(cur_conn, cur_bytes, cur_base, data_pkt, data_word);
          assert (tx_data_data == e.data) else begin
            $display("error tx_data_data got %h expected %h", tx_data_data, e.data);
            errors++;
          end
          assert (tx_data_keep == e.keep) else begin
            $display("error tx_data_keep got %h expected %h", tx_data_keep, e.keep);
            errors++;
          end
          assert (tx_data_last == e.last) else begin
            $display("error tx_data_last got %h expected %h", tx_data_last, e.last);
            errors++;
          end
          if (e.last) begin
            data_pkt++;
            data_word = 0;
          end else begin
            data_word++;
          end
        end
        data_cnt++;
      end
      if (tx_data_valid && !tx_data_ready) stall_seen++;
    end
  end

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge ap_clk);
    #1 penable = 1'b1;
    @(posedge ap_clk);  // access edge
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge ap_clk);
    #1 penable = 1'b1;
    @(negedge ap_clk);
    data = prdata;  // mid access phase
    @(posedge ap_clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_reg(input logic [11:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] got;
    read_reg(addr, got);
    assert (got === exp) else begin
      $display("error %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic program_run(input int unsigned conn, input int unsigned nbytes,
                             input int unsigned npkt, input logic [15:0] base);
    cur_conn   = conn;
    cur_bytes  = nbytes;
    cur_num    = npkt;
    cur_base   = base;
    meta_cnt   = 0;
    data_cnt   = 0;
    data_pkt   = 0;
    data_word  = 0;
    stall_seen = 0;
    write_reg(REG_USE_CONN, conn);
    write_reg(REG_PKG_BYTES, nbytes);
    write_reg(REG_PKG_NUM, npkt);
    write_reg(REG_BASE_SESSION, {16'h0, base});
    write_reg(REG_CTRL, 32'h1);
  endtask

  task automatic wait_done();
    logic [31:0] st;
    st = '0;
    while (!st[CTRL_DONE_BIT]) read_reg(REG_CTRL, st);  // bounded by the cycle counter
  endtask

  task automatic check_counts();
    int unsigned words;
    words = cur_num * ((cur_bytes + 7) / 8);
    assert (meta_cnt == cur_num) else begin
      $display("error tx_meta beat count got %h expected %h", meta_cnt, cur_num);
      errors++;
    end
    assert (data_cnt == words) else begin
      $display("error tx_data beat count got %h expected %h", data_cnt, words);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  initial begin
    ap_rst_n     = 1'b0;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    bp_on        = 1'b0;
    cur_conn     = 0;
    cur_bytes    = 0;
    cur_num      = 0;  // any beat before a run counts as unexpected
    cur_base     = '0;
    meta_cnt     = 0;
    data_cnt     = 0;
    data_pkt     = 0;
    data_word    = 0;
    stall_seen   = 0;
    errors       = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(posedge ap_clk);
    #1 ap_rst_n = 1'b1;

    repeat (8) begin
      @(negedge ap_clk);
      assert (!tx_meta_valid && !tx_data_valid) else begin
        $display("valid output raised before any start");
        errors++;
      end
    end
    @(posedge ap_clk);
    #1;
    check_reg(REG_CTRL, 32'h4, "status");
    check_reg(REG_TX_BYTES, 32'h0, "tx_bytes");
    check_reg(REG_TX_PKTS, 32'h0, "tx_pkts");
    check_reg(REG_STALL_CYCLES, 32'h0, "stall_cycles");
    finish_test("reset state");

    program_run(3, 64, 6, 16'h0100);
    wait_done();
    check_counts();
    check_reg(REG_CTRL, 32'h6, "status");  // done and idle
    finish_test("round robin run");

    program_run(2, 21, 5, 16'h0200);
    wait_done();
    check_counts();
    check_reg(REG_TX_BYTES, 21 * 5, "tx_bytes");
    check_reg(REG_TX_PKTS, 5, "tx_pkts");
    finish_test("partial last word");

    bp_on = 1'b1;
    program_run(4, 44, 8, 16'hfffe);  // session wraps past 0xffff
    wait_done();
    bp_on = 1'b0;
    check_counts();
    check_reg(REG_STALL_CYCLES, stall_seen, "stall_cycles");
    finish_test("random back-pressure");

    program_run(2, 16, 4, 16'h0300);
    while (data_pkt == 0) @(posedge ap_clk);  // first packet already counted
    #1;
    write_reg(REG_CTRL, 32'h1);     // busy, no restart
    write_reg(REG_PKG_NUM, 32'd9);  // frozen during the run
    wait_done();
    check_counts();
    check_reg(REG_TX_PKTS, 4, "tx_pkts");
    check_reg(REG_TX_BYTES, 64, "tx_bytes");
    program_run(2, 16, 0, 16'h0300);
    repeat (20) @(posedge ap_clk);
    #1;
    check_reg(REG_CTRL, 32'h6, "status");  // still idle, done kept
    check_counts();
    finish_test("ignored starts");

    write_reg(REG_USE_CONN, 32'd7);
    write_reg(REG_PKG_BYTES, 32'd100);
    write_reg(REG_PKG_NUM, 32'd3);
    write_reg(REG_BASE_SESSION, 32'h0000abcd);
    check_reg(REG_USE_CONN, 32'd7, "use_conn");
    check_reg(REG_PKG_BYTES, 32'd100, "pkg_bytes");
    check_reg(REG_PKG_NUM, 32'd3, "pkg_num");
    check_reg(REG_BASE_SESSION, 32'h0000abcd, "base_session");
    finish_test("config readback");

    errors = errors + i_scatter_top.u_props.fail_count;  // bound property failures
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- verilog/scatter_cfg_pkg.sv
/*
  scatter control register map
  APB geometry, register offsets and control bit positions of the
  host-side register block, plus the counter type shared with the
  statistics stage
*/
package scatter_cfg_pkg;

  localparam int APB_ADDR_W = 12;
  localparam int APB_DATA_W = 32;

  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // packet count, packet bytes and statistics
  typedef logic [31:0] count_t;

  localparam apb_addr_t REG_CTRL         = 12'h000;
  localparam apb_addr_t REG_USE_CONN     = 12'h010;
  localparam apb_addr_t REG_PKG_BYTES    = 12'h014;
  localparam apb_addr_t REG_PKG_NUM      = 12'h018;
  localparam apb_addr_t REG_BASE_SESSION = 12'h01C;
  localparam apb_addr_t REG_TX_BYTES     = 12'h020;  // read only
  localparam apb_addr_t REG_TX_PKTS      = 12'h024;  // read only
  localparam apb_addr_t REG_STALL_CYCLES = 12'h028;  // read only

  // bits of REG_CTRL
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_DONE_BIT  = 1;
  localparam int CTRL_IDLE_BIT  = 2;

endpackage

//--- verilog/scatter_ctrl_regs.sv
/*
  scatter register block
  APB slave without wait states holding the run configuration, the
  start request and the idle/done status; statistics are read back
  from the transmit side
*/
module scatter_ctrl_regs (
  input  logic                                   ap_clk,
  input  logic                                   ap_rst_n,
  input  logic [scatter_cfg_pkg::APB_ADDR_W-1:0] paddr,
  input  logic                                   psel,
  input  logic                                   penable,
  input  logic                                   pwrite,
  input  logic [scatter_cfg_pkg::APB_DATA_W-1:0] pwdata,
  output logic [scatter_cfg_pkg::APB_DATA_W-1:0] prdata,
  scatter_run_if.ctrl                            run
);
  import scatter_cfg_pkg::*;
  import scatter_stream_pkg::*;

  count_t    use_conn_q;
  count_t    pkg_bytes_q;
  count_t    pkg_num_q;
  session_t  base_session_q;
  logic      start_q;
  logic      idle;
  logic      done_q;
  logic      wr_en;
  logic      cfg_ok;
  logic      start_req;
  apb_data_t status;

  assign wr_en  = psel & penable & pwrite;  // access phase edge
  assign cfg_ok = (use_conn_q != '0) && (pkg_bytes_q != '0) && (pkg_num_q != '0);

  // start only from idle with a usable configuration
  assign start_req = wr_en && (paddr == REG_CTRL) && pwdata[CTRL_START_BIT]
                     && idle && cfg_ok;

  // configuration is frozen while a run is in flight
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      use_conn_q     <= '0;
      pkg_bytes_q    <= '0;
      pkg_num_q      <= '0;
      base_session_q <= '0;
    end else if (wr_en && idle) begin
      case (paddr)
        REG_USE_CONN:     use_conn_q     <= pwdata;
        REG_PKG_BYTES:    pkg_bytes_q    <= pwdata;
        REG_PKG_NUM:      pkg_num_q      <= pwdata;
        REG_BASE_SESSION: base_session_q <= session_t'(pwdata);
        default: ;
      endcase
    end
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      start_q <= 1'b0;
      idle    <= 1'b1;
      done_q  <= 1'b0;
    end else begin
      start_q <= start_req;
      if (start_req) begin
        idle   <= 1'b0;  // falls together with the start pulse
        done_q <= 1'b0;
      end else if (run.done) begin
        idle   <= 1'b1;
        done_q <= 1'b1;  // sticky until next accepted start
      end
    end
  end

  assign run.start        = start_q;
  assign run.use_conn     = use_conn_q;
  assign run.pkg_bytes    = pkg_bytes_q;
  assign run.pkg_num      = pkg_num_q;
  assign run.base_session = base_session_q;

  always_comb begin
    status                 = '0;
    status[CTRL_START_BIT] = start_q;
    status[CTRL_DONE_BIT]  = done_q;
    status[CTRL_IDLE_BIT]  = idle;
  end

  // read data valid through the access phase
  always_comb begin
    case (paddr)
      REG_CTRL:         prdata = status;
      REG_USE_CONN:     prdata = use_conn_q;
      REG_PKG_BYTES:    prdata = pkg_bytes_q;
      REG_PKG_NUM:      prdata = pkg_num_q;
      REG_BASE_SESSION: prdata = apb_data_t'(base_session_q);
      REG_TX_BYTES:     prdata = run.tx_bytes;
      REG_TX_PKTS:      prdata = run.tx_pkts;
      REG_STALL_CYCLES: prdata = run.stall_cycles;
      default:          prdata = '0;
    endcase
  end

endmodule

//--- verilog/scatter_run_if.sv
/*
  scatter run bundle
  start pulse and run configuration from the register block, done pulse
  and statistics back to it
*/
interface scatter_run_if;
  import scatter_cfg_pkg::*;
  import scatter_stream_pkg::*;

  logic     start;         // one cycle
  count_t   use_conn;
  count_t   pkg_bytes;
  count_t   pkg_num;
  session_t base_session;
  logic     done;          // one cycle
  count_t   tx_bytes;
  count_t   tx_pkts;
  count_t   stall_cycles;

  modport ctrl (
    output start, use_conn, pkg_bytes, pkg_num, base_session,
    input  done, tx_bytes, tx_pkts, stall_cycles
  );

  modport gen (input start, use_conn, pkg_bytes, pkg_num, base_session);

  modport stats (input start, pkg_num, output done, tx_bytes, tx_pkts, stall_cycles);

endinterface

//--- verilog/scatter_stream_pkg.sv
/*
  scatter transmit stream definitions
  widths and payload structs of the TCP transmit metadata and data
  streams, and the depth of the output buffers
*/
package scatter_stream_pkg;

  localparam int DATA_W     = 64;
  localparam int KEEP_W     = DATA_W / 8;
  localparam int FIFO_DEPTH = 4;

  typedef logic [15:0] session_t;
  typedef logic [15:0] len_t;

  // one metadata word per packet
  typedef struct packed {
    session_t session;
    len_t     length;  // bytes
  } tx_meta_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [KEEP_W-1:0] keep;  // contiguous from byte 0
    logic              last;
  } tx_word_t;

endpackage

//--- verilog/scatter_top.sv
/*
  scatter transmit engine
  APB register block, packet generator, two output FIFOs and the
  statistics stage driving the TCP transmit metadata and data ports
*/
module scatter_top (
  input  logic                                             ap_clk,
  input  logic                                             ap_rst_n,
  input  logic [scatter_cfg_pkg::APB_ADDR_W-1:0]           paddr,
  input  logic                                             psel,
  input  logic                                             penable,
  input  logic                                             pwrite,
  input  logic [scatter_cfg_pkg::APB_DATA_W-1:0]           pwdata,
  output logic [scatter_cfg_pkg::APB_DATA_W-1:0]           prdata,
  output logic                                             tx_meta_valid,
  input  logic                                             tx_meta_ready,
  output logic [$bits(scatter_stream_pkg::tx_meta_t)-1:0] tx_meta_data,
  output logic                                             tx_data_valid,
  input  logic                                             tx_data_ready,
  output logic [scatter_stream_pkg::DATA_W-1:0]            tx_data_data,
  output logic [scatter_stream_pkg::KEEP_W-1:0]            tx_data_keep,
  output logic                                             tx_data_last
);
  import scatter_stream_pkg::*;

  logic     gen_meta_valid;
  logic     gen_meta_ready;
  tx_meta_t gen_meta_data;
  logic     gen_word_valid;
  logic     gen_word_ready;
  tx_word_t gen_word_data;
  logic     buf_meta_valid;
  logic     buf_meta_ready;
  tx_meta_t buf_meta_data;
  logic     buf_word_valid;
  logic     buf_word_ready;
  tx_word_t buf_word_data;

  scatter_run_if run ();

  scatter_ctrl_regs u_ctrl_regs (
    .ap_clk, .ap_rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
    .run (run.ctrl)
  );

  scatter_tx_gen u_tx_gen (
    .ap_clk, .ap_rst_n,
    .run        (run.gen),
    .meta_valid (gen_meta_valid),
    .meta_ready (gen_meta_ready),
    .meta_data  (gen_meta_data),
    .word_valid (gen_word_valid),
    .word_ready (gen_word_ready),
    .word_data  (gen_word_data)
  );

  stream_fifo #(.payload_t(tx_meta_t), .DEPTH(FIFO_DEPTH)) u_meta_fifo (
    .ap_clk, .ap_rst_n,
    .in_valid  (gen_meta_valid),
    .in_ready  (gen_meta_ready),
    .in_data   (gen_meta_data),
    .out_valid (buf_meta_valid),
    .out_ready (buf_meta_ready),
    .out_data  (buf_meta_data)
  );

  stream_fifo #(.payload_t(tx_word_t), .DEPTH(FIFO_DEPTH)) u_data_fifo (
    .ap_clk, .ap_rst_n,
    .in_valid  (gen_word_valid),
    .in_ready  (gen_word_ready),
    .in_data   (gen_word_data),
    .out_valid (buf_word_valid),
    .out_ready (buf_word_ready),
    .out_data  (buf_word_data)
  );

  scatter_tx_stats u_tx_stats (
    .ap_clk, .ap_rst_n,
    .run           (run.stats),
    .meta_in_valid (buf_meta_valid),
    .meta_in_ready (buf_meta_ready),
    .meta_in_data  (buf_meta_data),
    .word_in_valid (buf_word_valid),
    .word_in_ready (buf_word_ready),
    .word_in_data  (buf_word_data),
    .tx_meta_valid, .tx_meta_ready, .tx_meta_data,
    .tx_data_valid, .tx_data_ready, .tx_data_data, .tx_data_keep, .tx_data_last
  );

endmodule

//--- verilog/scatter_tx_gen.sv
/*
  scatter packet generator
  walks pkg_num packets round robin over use_conn sessions; each packet
  is one metadata word followed by ceil(pkg_bytes/8) data words
*/
module scatter_tx_gen (
  input  logic                         ap_clk,
  input  logic                         ap_rst_n,
  scatter_run_if.gen                   run,
  output logic                         meta_valid,
  input  logic                         meta_ready,
  output scatter_stream_pkg::tx_meta_t meta_data,
  output logic                         word_valid,
  input  logic                         word_ready,
  output scatter_stream_pkg::tx_word_t word_data
);
  import scatter_cfg_pkg::*;
  import scatter_stream_pkg::*;

  typedef enum logic [1:0] {
    GEN_IDLE,
    GEN_META,
    GEN_DATA
  } gen_state_t;

  gen_state_t        state;
  count_t            pkt_idx;
  count_t            conn_idx;
  count_t            word_idx;
  count_t            words_per_pkt;
  logic [2:0]        tail_bytes;
  logic              last_word;
  logic [KEEP_W-1:0] keep;
  session_t          session;

  assign words_per_pkt = {3'b000, run.pkg_bytes[31:3]} + count_t'(|run.pkg_bytes[2:0]);
  assign tail_bytes    = run.pkg_bytes[2:0];
  assign last_word     = (word_idx == words_per_pkt - 32'd1);
  assign session       = run.base_session + session_t'(conn_idx);

  // partial tail gets a low contiguous mask
  assign keep = (last_word && tail_bytes != 3'd0) ? ~({KEEP_W{1'b1}} << tail_bytes)
                                                  : {KEEP_W{1'b1}};

  assign meta_valid = (state == GEN_META);
  assign meta_data  = {session, len_t'(run.pkg_bytes)};
  assign word_valid = (state == GEN_DATA);
  assign word_data  = {session, session_t'(pkt_idx), word_idx, keep, last_word};

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      state    <= GEN_IDLE;
      pkt_idx  <= '0;
      conn_idx <= '0;
      word_idx <= '0;
    end else begin
      case (state)
        GEN_IDLE: if (run.start) begin
          state    <= GEN_META;  // first metadata offered next cycle
          pkt_idx  <= '0;
          conn_idx <= '0;
        end
        GEN_META: if (meta_ready) begin
          state    <= GEN_DATA;
          word_idx <= '0;
        end
        GEN_DATA: if (word_ready) begin
          if (last_word) begin
            pkt_idx  <= pkt_idx + 32'd1;
            conn_idx <= (conn_idx == run.use_conn - 32'd1) ? '0 : conn_idx + 32'd1;
            state    <= (pkt_idx + 32'd1 == run.pkg_num) ? GEN_IDLE : GEN_META;
          end else begin
            word_idx <= word_idx + 32'd1;
          end
        end
        default: state <= GEN_IDLE;
      endcase
    end
  end

endmodule

//--- verilog/scatter_tx_stats.sv
/*
  scatter transmit statistics
  passes both buffered streams to the ports, counts accepted bytes,
  packets and data stall cycles, and flags the end of a run
*/
module scatter_tx_stats (
  input  logic                                             ap_clk,
  input  logic                                             ap_rst_n,
  scatter_run_if.stats                                     run,
  input  logic                                             meta_in_valid,
  output logic                                             meta_in_ready,
  input  scatter_stream_pkg::tx_meta_t                     meta_in_data,
  input  logic                                             word_in_valid,
  output logic                                             word_in_ready,
  input  scatter_stream_pkg::tx_word_t                     word_in_data,
  output logic                                             tx_meta_valid,
  input  logic                                             tx_meta_ready,
  output logic [$bits(scatter_stream_pkg::tx_meta_t)-1:0] tx_meta_data,
  output logic                                             tx_data_valid,
  input  logic                                             tx_data_ready,
  output logic [scatter_stream_pkg::DATA_W-1:0]            tx_data_data,
  output logic [scatter_stream_pkg::KEEP_W-1:0]            tx_data_keep,
  output logic                                             tx_data_last
);
  import scatter_cfg_pkg::*;

  logic   data_fire;
  count_t pkts_next;

  assign tx_meta_valid = meta_in_valid;
  assign meta_in_ready = tx_meta_ready;
  assign tx_meta_data  = meta_in_data;

  assign tx_data_valid = word_in_valid;
  assign word_in_ready = tx_data_ready;
  assign tx_data_data  = word_in_data.data;
  assign tx_data_keep  = word_in_data.keep;
  assign tx_data_last  = word_in_data.last;

  assign data_fire = tx_data_valid & tx_data_ready;
  assign pkts_next = run.tx_pkts + 32'd1;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n || run.start) begin
      run.tx_bytes     <= '0;
      run.tx_pkts      <= '0;
      run.stall_cycles <= '0;
      run.done         <= 1'b0;
    end else begin
      run.done <= data_fire && tx_data_last && (pkts_next == run.pkg_num);
      if (data_fire) run.tx_bytes <= run.tx_bytes + count_t'($countones(tx_data_keep));
      if (data_fire && tx_data_last) run.tx_pkts <= pkts_next;
      if (tx_data_valid && !tx_data_ready) begin
        run.stall_cycles <= run.stall_cycles + 32'd1;  // port back-pressure
      end
    end
  end

endmodule

//--- verilog/stream_fifo.sv
/*
  stream FIFO
  circular buffer with valid/ready on both sides, any packed payload;
  push and pop may happen in the same cycle
*/
module stream_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     ap_clk,
  input  logic     ap_rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t             mem [DEPTH];
  logic     [PTR_W-1:0] wr_ptr;
  logic     [PTR_W-1:0] rd_ptr;
  logic     [CNT_W-1:0] count;
  logic                 push;
  logic                 pop;

  assign in_ready  = (count != CNT_W'(DEPTH));  // low when full
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  always_ff @(posedge ap_clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both
      endcase
    end
  end

endmodule

//--- vlog.f
verilog/scatter_cfg_pkg.sv
verilog/scatter_stream_pkg.sv
verilog/scatter_run_if.sv
verilog/scatter_ctrl_regs.sv
verilog/scatter_tx_gen.sv
verilog/stream_fifo.sv
verilog/scatter_tx_stats.sv
verilog/scatter_top.sv
tests/scatter_props.sv
tests/tb_scatter.sv
